/* Bender.yml */
package:
  name: l2_tag_dir

sources:
  - source/l2_pkg.sv
  - source/sram_1r1w.sv
  - source/cache_lru.sv
  - source/l2_cache_tag.sv
  - source/l2_cache_dir.sv
  - source/l2_tag_dir_top.sv
  - target: test
    files:
      - verif/l2_tag_dir_tb.sv

/* l2_tag_dir.f */
source/l2_pkg.sv
source/sram_1r1w.sv
source/cache_lru.sv
source/l2_cache_tag.sv
source/l2_cache_dir.sv
source/l2_tag_dir_top.sv
verif/l2_tag_dir_tb.sv

/* source/cache_lru.sv */
// Four-way tree pseudo-LRU storage with registered victim read and touch update
module cache_lru #(
	parameter int DEPTH = 64
) (
	input logic clk,
	input logic reset,
	input logic rd_en_i,
	input logic [$clog2(DEPTH)-1:0] rd_set_i,
	input logic upd_en_i,
	input logic [$clog2(DEPTH)-1:0] upd_set_i,
	input logic [1:0] upd_way_i,
	output logic [1:0] victim_way_o
);
	// Bit 0 picks the older pair, bit 1 the older way of 0-1, bit 2 the older way of 2-3
	logic [2:0] tree [DEPTH];
	logic [2:0] touched_tree;

	function automatic logic [1:0] pick_victim(input logic [2:0] bits);
		if (bits[0])
			return {1'b1, bits[2]};
		else
			return {1'b0, bits[1]};
	endfunction

	// Make the used way the youngest, so both levels point away from it
	function automatic logic [2:0] touch(input logic [2:0] bits, input logic [1:0] way);
		logic [2:0] new_bits;

		new_bits = bits;
		new_bits[0] = ~way[1];
		if (way[1])
			new_bits[2] = ~way[0];
		else
			new_bits[1] = ~way[0];
		return new_bits;
	endfunction

	assign touched_tree = touch(tree[upd_set_i], upd_way_i);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < DEPTH; i++)
				tree[i] <= '0;
		end
		else if (upd_en_i)
			tree[upd_set_i] <= touched_tree;
	end

	// Same-set touch in this cycle wins over the stored tree
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			victim_way_o <= '0;
		else if (rd_en_i)
		begin
			if (upd_en_i && upd_set_i == rd_set_i)
				victim_way_o <= pick_victim(touched_tree);
			else
				victim_way_o <= pick_victim(tree[rd_set_i]);
		end
	end

endmodule

/* source/l2_cache_dir.sv */
// L2 directory stage with hit detection, fill victim choice, response register and updates
module l2_cache_dir (
	input logic clk,
	input logic reset,
	input l2_pkg::l2_req_t req_i,
	input l2_pkg::l2_tag_entry_t [l2_pkg::L2_NUM_WAYS-1:0] tags_i,
	input logic [l2_pkg::L2_NUM_WAYS-1:0] dirty_i,
	input logic [l2_pkg::L2_WAY_WIDTH-1:0] lru_way_i,
	output l2_pkg::l2_resp_t resp_o,
	output l2_pkg::l2_update_t update_o
);
	logic [l2_pkg::L2_TAG_WIDTH-1:0] req_tag;
	logic [l2_pkg::L2_SET_WIDTH-1:0] req_set;
	logic [l2_pkg::L2_NUM_WAYS-1:0] hit_onehot;
	logic hit;
	logic [l2_pkg::L2_WAY_WIDTH-1:0] hit_way;
	logic [l2_pkg::L2_WAY_WIDTH-1:0] sel_way;
	logic is_load;
	logic is_store;
	logic is_fill;
	logic is_inval;
	logic writeback;
	l2_pkg::l2_tag_entry_t victim;

	assign req_tag = req_i.address[l2_pkg::L2_ADDR_WIDTH-1:l2_pkg::L2_SET_WIDTH];
	assign req_set = req_i.address[l2_pkg::L2_SET_WIDTH-1:0];

	for (genvar w = 0; w < l2_pkg::L2_NUM_WAYS; w++)
	begin : g_cmp
		assign hit_onehot[w] = tags_i[w].valid && tags_i[w].tag == req_tag;
	end

	assign hit = |hit_onehot;

	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < l2_pkg::L2_NUM_WAYS; w++)
		begin
			if (hit_onehot[w])
				hit_way = l2_pkg::L2_WAY_WIDTH'(w);
		end
	end

	assign is_load = req_i.valid && req_i.op == l2_pkg::OP_LOAD;
	assign is_store = req_i.valid && req_i.op == l2_pkg::OP_STORE;
	assign is_fill = req_i.valid && req_i.op == l2_pkg::OP_FILL;
	assign is_inval = req_i.valid && req_i.op == l2_pkg::OP_INVALIDATE;

	// Fills replace the LRU way, everything else works on the hit way
	assign sel_way = is_fill ? lru_way_i : hit_way;
	assign victim = tags_i[lru_way_i];
	assign writeback = is_fill && victim.valid && dirty_i[lru_way_i];

	always_comb
	begin
		update_o.tag_we = is_fill || (is_inval && hit);
		update_o.tag_way = sel_way;
		update_o.tag_set = req_set;
		update_o.tag_entry.valid = is_fill;
		update_o.tag_entry.tag = req_tag;
		// A new line starts clean, a store hit makes it dirty
		update_o.dirty_we = is_fill || (is_store && hit);
		update_o.dirty_way = sel_way;
		update_o.dirty_set = req_set;
		update_o.dirty_value = is_store;
		update_o.lru_we = is_fill || ((is_load || is_store) && hit);
		update_o.lru_set = req_set;
		update_o.lru_way = sel_way;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			resp_o <= '0;
		else
		begin
			resp_o.valid <= req_i.valid;
			resp_o.op <= req_i.op;
			resp_o.address <= req_i.address;
			resp_o.hit <= hit;
			resp_o.way <= (hit || is_fill) ? sel_way : '0;
			// Dirty state as it was before this request's update
			resp_o.dirty <= (hit || is_fill) && dirty_i[sel_way];
			resp_o.writeback <= writeback;
			resp_o.victim_tag <= is_fill ? victim.tag : '0;
		end
	end

	// Fills are only issued for lines missing from the cache
	a_fill_no_hit: assert property (@(posedge clk) disable iff (reset)
		is_fill |-> !hit)
		else $error("fill request hit a tag already present in the set");

	a_single_hit: assert property (@(posedge clk) disable iff (reset)
		req_i.valid |-> $onehot0(hit_onehot))
		else $error("tag present in more than one way of a set");

endmodule

/* source/l2_cache_tag.sv */
// L2 tag stage with tag, dirty and LRU memory reads and the request pipeline register
module l2_cache_tag #(
	parameter int NUM_SETS = 64
) (
	input logic clk,
	input logic reset,
	input l2_pkg::l2_req_t req_i,
	input l2_pkg::l2_update_t update_i,
	output l2_pkg::l2_req_t req_o,
	output l2_pkg::l2_tag_entry_t [l2_pkg::L2_NUM_WAYS-1:0] tags_o,
	output logic [l2_pkg::L2_NUM_WAYS-1:0] dirty_o,
	output logic [l2_pkg::L2_WAY_WIDTH-1:0] lru_way_o
);
	logic [l2_pkg::L2_SET_WIDTH-1:0] rd_set;
	logic [l2_pkg::L2_NUM_WAYS-1:0] tag_we;
	logic [l2_pkg::L2_NUM_WAYS-1:0] dirty_we;

	// The set index width in the structs is fixed, so the depth has to agree with it
	if (NUM_SETS != 2 ** l2_pkg::L2_SET_WIDTH)
	begin : g_depth_check
		$error("NUM_SETS does not match the set index width");
	end

	assign rd_set = req_i.address[l2_pkg::L2_SET_WIDTH-1:0];

	for (genvar w = 0; w < l2_pkg::L2_NUM_WAYS; w++)
	begin : g_way
		// Each way has its own memories, so the update way becomes a write enable
		assign tag_we[w] = update_i.tag_we &&
			update_i.tag_way == l2_pkg::L2_WAY_WIDTH'(w);
		assign dirty_we[w] = update_i.dirty_we &&
			update_i.dirty_way == l2_pkg::L2_WAY_WIDTH'(w);

		sram_1r1w #(
			.ENTRY_T(l2_pkg::l2_tag_entry_t),
			.DEPTH(NUM_SETS)
		) u_tag_mem (
			.clk(clk),
			.reset(reset),
			.rd_en_i(req_i.valid),
			.rd_addr_i(rd_set),
			.wr_en_i(tag_we[w]),
			.wr_addr_i(update_i.tag_set),
			.wr_data_i(update_i.tag_entry),
			.rd_data_o(tags_o[w])
		);

		sram_1r1w #(
			.ENTRY_T(logic),
			.DEPTH(NUM_SETS)
		) u_dirty_mem (
			.clk(clk),
			.reset(reset),
			.rd_en_i(req_i.valid),
			.rd_addr_i(rd_set),
			.wr_en_i(dirty_we[w]),
			.wr_addr_i(update_i.dirty_set),
			.wr_data_i(update_i.dirty_value),
			.rd_data_o(dirty_o[w])
		);
	end

	cache_lru #(
		.DEPTH(NUM_SETS)
	) u_lru (
		.clk(clk),
		.reset(reset),
		.rd_en_i(req_i.valid),
		.rd_set_i(rd_set),
		.upd_en_i(update_i.lru_we),
		.upd_set_i(update_i.lru_set),
		.upd_way_i(update_i.lru_way),
		.victim_way_o(lru_way_o)
	);

	// Request moves on together with the memory read data
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			req_o <= '0;
		else
			req_o <= req_i;
	end

endmodule

/* source/l2_pkg.sv */
// L2 tag pipeline geometry, operation codes and request, response, tag and update structs
package l2_pkg;

	// Four-way set-associative, 64 sets, addressed by 20-bit line address
	parameter int L2_NUM_WAYS = 4;
	parameter int L2_WAY_WIDTH = $clog2(L2_NUM_WAYS);
	parameter int L2_SET_WIDTH = 6;
	parameter int L2_ADDR_WIDTH = 20;

	// The set index is the low part of the line address, the tag is the rest
	parameter int L2_TAG_WIDTH = L2_ADDR_WIDTH - L2_SET_WIDTH;

	typedef enum logic [1:0] {
		OP_LOAD = 2'd0,
		OP_STORE = 2'd1,
		OP_FILL = 2'd2,
		OP_INVALIDATE = 2'd3
	} l2_op_t;

	typedef struct packed {
		logic valid;
		l2_op_t op;
		logic [L2_ADDR_WIDTH-1:0] address;
	} l2_req_t;

	typedef struct packed {
		logic valid;
		logic [L2_TAG_WIDTH-1:0] tag;
	} l2_tag_entry_t;

	// Way is the hit way, or the replaced way for a fill
	typedef struct packed {
		logic valid;
		l2_op_t op;
		logic [L2_ADDR_WIDTH-1:0] address;
		logic hit;
		logic [L2_WAY_WIDTH-1:0] way;
		logic dirty;
		logic writeback;
		logic [L2_TAG_WIDTH-1:0] victim_tag;
	} l2_resp_t;

	// Writes from the directory stage back into the tag stage memories
	typedef struct packed {
		logic tag_we;
		logic [L2_WAY_WIDTH-1:0] tag_way;
		logic [L2_SET_WIDTH-1:0] tag_set;
		l2_tag_entry_t tag_entry;
		logic dirty_we;
		logic [L2_WAY_WIDTH-1:0] dirty_way;
		logic [L2_SET_WIDTH-1:0] dirty_set;
		logic dirty_value;
		logic lru_we;
		logic [L2_SET_WIDTH-1:0] lru_set;
		logic [L2_WAY_WIDTH-1:0] lru_way;
	} l2_update_t;

endpackage

/* source/l2_tag_dir_top.sv */
// Top level of the L2 tag and directory pipeline
module l2_tag_dir_top #(
	parameter int NUM_SETS = 64
) (
	input logic clk,
	input logic reset,
	input l2_pkg::l2_req_t req_i,
	output l2_pkg::l2_resp_t resp_o
);
	l2_pkg::l2_req_t tag_req;
	l2_pkg::l2_tag_entry_t [l2_pkg::L2_NUM_WAYS-1:0] tag_entries;
	logic [l2_pkg::L2_NUM_WAYS-1:0] tag_dirty;
	logic [l2_pkg::L2_WAY_WIDTH-1:0] tag_lru_way;
	l2_pkg::l2_update_t dir_update;

	l2_cache_tag #(
		.NUM_SETS(NUM_SETS)
	) u_l2_cache_tag (
		.clk(clk),
		.reset(reset),
		.req_i(req_i),
		.update_i(dir_update),
		.req_o(tag_req),
		.tags_o(tag_entries),
		.dirty_o(tag_dirty),
		.lru_way_o(tag_lru_way)
	);

	// Updates go straight back into the tag stage memories
	l2_cache_dir u_l2_cache_dir (
		.clk(clk),
		.reset(reset),
		.req_i(tag_req),
		.tags_i(tag_entries),
		.dirty_i(tag_dirty),
		.lru_way_i(tag_lru_way),
		.resp_o(resp_o),
		.update_o(dir_update)
	);

endmodule

/* source/sram_1r1w.sv */
// Synchronous one-read one-write memory with reset clearing and write-first read bypass
module sram_1r1w #(
	parameter type ENTRY_T = logic,
	parameter int DEPTH = 64
) (
	input logic clk,
	input logic reset,
	input logic rd_en_i,
	input logic [$clog2(DEPTH)-1:0] rd_addr_i,
	input logic wr_en_i,
	input logic [$clog2(DEPTH)-1:0] wr_addr_i,
	input ENTRY_T wr_data_i,
	output ENTRY_T rd_data_o
);
	ENTRY_T mem [DEPTH];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
		end
		else if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// A read that lands on the address being written sees the new data
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rd_data_o <= '0;
		else if (rd_en_i)
			rd_data_o <= (wr_en_i && wr_addr_i == rd_addr_i) ? wr_data_i : mem[rd_addr_i];
	end

	a_rd_addr_range: assert property (@(posedge clk) disable iff (reset)
		rd_en_i |-> rd_addr_i < DEPTH)
		else $error("read address beyond memory depth");

	a_wr_addr_range: assert property (@(posedge clk) disable iff (reset)
		wr_en_i |-> wr_addr_i < DEPTH)
		else $error("write address beyond memory depth");

endmodule

/* verif/l2_tag_dir_cases.txt */
# test op address(hex) | expected: hit way dirty writeback victim_tag(hex)
# op is load, store, fill or inval; address is the 20-bit line address, set in the low 6 bits
1 load  00045 0 0 0 0 0000
1 store 00085 0 0 0 0 0000
1 inval 00105 0 0 0 0 0000
1 load  fffff 0 0 0 0 0000
2 fill  00045 0 0 0 0 0000
2 fill  00085 0 2 0 0 0000
2 fill  000c5 0 1 0 0 0000
2 fill  00105 0 3 0 0 0000
2 load  00045 1 0 0 0 0000
2 load  00085 1 2 0 0 0000
2 load  000c5 1 1 0 0 0000
2 load  00105 1 3 0 0 0000
3 store 00045 1 0 0 0 0000
3 load  00045 1 0 1 0 0000
3 load  00085 1 2 0 0 0000
3 load  000c5 1 1 0 0 0000
3 load  00105 1 3 0 0 0000
3 fill  00145 0 0 1 1 0001
3 load  00045 0 0 0 0 0000
3 load  00145 1 0 0 0 0000
4 store 000c5 1 1 0 0 0000
4 inval 000c5 1 1 1 0 0000
4 load  000c5 0 0 0 0 0000
4 inval 00085 1 2 0 0 0000
4 load  00085 0 0 0 0 0000
5 fill  0aac9 0 0 0 0 0000
5 load  0aac9 1 0 0 0 0000
5 store 0aac9 1 0 0 0 0000
5 load  0aac9 1 0 1 0 0000
5 load  0aac5 0 0 0 0 0000
5 load  00105 1 3 0 0 0000
5 fill  0004a 0 0 0 0 0000
5 load  0004a 1 0 0 0 0000
5 fill  0ab09 0 2 0 0 0000
5 load  0ab09 1 2 0 0 0000

/* verif/l2_tag_dir_tb.sv */
// Testbench for the L2 tag and directory pipeline with file-driven requests and response checks
module l2_tag_dir_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 10;
	localparam int DRAIN_CYCLES = 8;
	// Rising edges from driving a request to its response being registered
	localparam int LATENCY = 2;

	// One request from the case file together with the response it must produce
	typedef struct packed {
		logic [7:0] test;
		logic last;
		l2_pkg::l2_resp_t resp;
	} case_t;

	logic clk;
	logic reset;
	l2_pkg::l2_req_t req;
	l2_pkg::l2_resp_t resp;

	case_t cases[$];
	case_t expect_q[$];
	int issue_q[$];
	int cycle_count = 0;
	int cycle_limit = 0;
	int errors = 0;
	int checks = 0;
	int tests_done = 0;
	int cases_done = 0;
	int test_cases = 0;
	int test_start_errors = 0;

	l2_tag_dir_top #(
		.NUM_SETS(64)
	) u_l2_tag_dir_top (
		.clk(clk),
		.reset(reset),
		.req_i(req),
		.resp_o(resp)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// Counts rising edges, so the response latency can be measured
	always @(posedge clk)
		cycle_count++;

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic load_cases(output bit ok);
		int fd;
		int nread;
		string line;
		string op_name;
		logic [31:0] test;
		logic [31:0] addr;
		logic [31:0] hit;
		logic [31:0] way;
		logic [31:0] dirty;
		logic [31:0] wb;
		logic [31:0] vtag;
		case_t c;

		ok = 1'b1;
		fd = $fopen("verif/l2_tag_dir_cases.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the case file verif/l2_tag_dir_cases.txt");
			ok = 1'b0;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				// Blank lines and lines starting with a hash are skipped
				if (line.len() > 1 && line.substr(0, 0) != "#")
				begin
					nread = $sscanf(line, "%d %s %h %d %d %d %d %h",
						test, op_name, addr, hit, way, dirty, wb, vtag);
					if (nread != 8)
					begin
						$display("malformed line in the case file: %s", line);
						ok = 1'b0;
					end
					else
					begin
						c = '0;
						c.test = test[7:0];
						c.resp.valid = 1'b1;
						case (op_name)
							"load": c.resp.op = l2_pkg::OP_LOAD;
							"store": c.resp.op = l2_pkg::OP_STORE;
							"fill": c.resp.op = l2_pkg::OP_FILL;
							"inval": c.resp.op = l2_pkg::OP_INVALIDATE;
							default:
							begin
								$display("unknown operation %s in the case file", op_name);
								ok = 1'b0;
							end
						endcase
						c.resp.address = addr[l2_pkg::L2_ADDR_WIDTH-1:0];
						c.resp.hit = hit[0];
						c.resp.way = way[l2_pkg::L2_WAY_WIDTH-1:0];
						c.resp.dirty = dirty[0];
						c.resp.writeback = wb[0];
						c.resp.victim_tag = vtag[l2_pkg::L2_TAG_WIDTH-1:0];
						cases.push_back(c);
					end
				end
			end
			$fclose(fd);
			// A test ends where the next case carries a different test number
			foreach (cases[i])
				cases[i].last = (i == cases.size() - 1) || (cases[i+1].test != cases[i].test);
			if (cases.size() == 0)
			begin
				$display("the case file holds no cases");
				ok = 1'b0;
			end
		end
	endtask

	// Responses are compared half a cycle after they are registered
	always @(negedge clk)
	begin
		case_t exp;
		int issued;

		if (!reset && resp.valid)
		begin
			if (expect_q.size() == 0)
			begin
				$display("response for address %0h arrived with no request outstanding",
					resp.address);
				errors++;
			end
			else
			begin
				exp = expect_q.pop_front();
				issued = issue_q.pop_front();
				if (cycle_count - issued != LATENCY)
				begin
					$display("response for address %0h came %0d cycles after its request, not %0d",
						resp.address, cycle_count - issued, LATENCY);
					errors++;
				end
				check_value("resp_o.op", resp.op, exp.resp.op);
				check_value("resp_o.address", resp.address, exp.resp.address);
				check_value("resp_o.hit", resp.hit, exp.resp.hit);
				check_value("resp_o.way", resp.way, exp.resp.way);
				check_value("resp_o.dirty", resp.dirty, exp.resp.dirty);
				check_value("resp_o.writeback", resp.writeback, exp.resp.writeback);
				check_value("resp_o.victim_tag", resp.victim_tag, exp.resp.victim_tag);
				cases_done++;
				test_cases++;
				if (exp.last)
				begin
					$display("test %0d done: %0d cases, %0d errors", exp.test, test_cases,
						errors - test_start_errors);
					tests_done++;
					test_cases = 0;
					test_start_errors = errors;
				end
			end
		end
	end

	initial
	begin
		int cycles;

		wait (cycle_limit != 0);
		cycles = 0;
		while (cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("run stopped after %0d cycles with %0d responses outstanding",
			cycles, expect_q.size());
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		bit loaded;
		int drain;

		reset = 1'b1;
		req = '0;
		load_cases(loaded);
		if (loaded)
		begin
			cycle_limit = cases.size() + RESET_CYCLES + 20;
			repeat (RESET_CYCLES) @(posedge clk);
			#1 reset = 1'b0;
			// One request per cycle, no gaps
			foreach (cases[i])
			begin
				@(posedge clk);
				#1;
				req.valid = 1'b1;
				req.op = cases[i].resp.op;
				req.address = cases[i].resp.address;
				expect_q.push_back(cases[i]);
				issue_q.push_back(cycle_count);
			end
			@(posedge clk);
			#1 req = '0;
			drain = 0;
			while (expect_q.size() != 0 && drain < DRAIN_CYCLES)
			begin
				@(posedge clk);
				drain++;
			end
			if (expect_q.size() != 0)
			begin
				$display("%0d expected responses never arrived", expect_q.size());
				errors++;
			end
		end
		else
			errors++;
		$display("%0d tests, %0d cases, %0d checks, %0d errors",
			tests_done, cases_done, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
